// ==== Bender.yml ====
package:
  name: mhp

sources:
  - files:
      - mhp_pkg.sv
      - buf_if.sv
      - frame_buf.sv
      - frame_receiver.sv
      - header_parser.sv
      - reply_builder.sv
      - frame_transmitter.sv
      - mhp_top.sv
  - target: test
    files:
      - mhp_assert.sv
      - tb_mhp.sv

// ==== buf_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface buf_if;
  import mhp_pkg::*;

  logic [BUF_AW-1:0] addr;
  logic              we;
  logic [7:0]        wdata;
  logic [7:0]        rdata;
  logic              en;

  modport master (
    output addr, we, wdata, en,
    input  rdata
  );

  modport memory (
    input  addr, we, wdata, en,
    output rdata
  );

endinterface

`default_nettype wire

// ==== frame_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buf (
  input  logic  i_clk,
  buf_if.memory bus
);
  import mhp_pkg::*;

  logic [7:0] mem [2**BUF_AW];

  // read data comes one cycle after the address, old data on a write
  always_ff @(posedge i_clk) begin
    if (bus.en) begin
      if (bus.we) begin
        mem[bus.addr] <= bus.wdata;
      end
      bus.rdata <= mem[bus.addr];
    end
  end

endmodule

`default_nettype wire

// ==== frame_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_receiver (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_start,
  input  logic [7:0]               i_rdata,
  input  logic                     i_rready,
  output logic                     o_rreq,
  buf_if.master                    bus,
  output logic                     o_done,
  output logic [mhp_pkg::BUF_AW:0] o_len
);
  import mhp_pkg::*;

  localparam int IDLE_W = $clog2(RX_IDLE_CYCLES + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LISTEN,
    ST_REQ,
    ST_CAPTURE
  } state_e;

  state_e            state;
  logic [IDLE_W-1:0] idle_cnt;
  logic [BUF_AW:0]   byte_cnt;
  logic              wr_en;
  logic [BUF_AW-1:0] wr_addr;
  logic [7:0]        wr_data;

  // idle_cnt counts cycles since the last request
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= ST_IDLE;
      o_rreq   <= 1'b0;
      o_done   <= 1'b0;
      idle_cnt <= '0;
      byte_cnt <= '0;
      wr_en    <= 1'b0;
    end else begin
      o_done <= 1'b0;
      wr_en  <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_start) begin
            idle_cnt <= '0;
            byte_cnt <= '0;
            state    <= ST_LISTEN;
          end
        end
        ST_LISTEN: begin
          if (i_rready) begin
            o_rreq   <= 1'b1;
            idle_cnt <= '0;
            state    <= ST_REQ;
          end else if (idle_cnt == IDLE_W'(RX_IDLE_CYCLES)) begin
            // empty quiet period, keep listening
            idle_cnt <= '0;
            if (byte_cnt != '0) begin
              o_done <= 1'b1;
              state  <= ST_IDLE;
            end
          end else begin
            idle_cnt <= idle_cnt + 1'b1;
          end
        end
        ST_REQ: begin
          o_rreq   <= 1'b0;
          idle_cnt <= idle_cnt + 1'b1;
          state    <= ST_CAPTURE;
        end
        ST_CAPTURE: begin
          idle_cnt <= idle_cnt + 1'b1;
          // drop anything past the buffer end
          if (!byte_cnt[BUF_AW]) begin
            wr_en    <= 1'b1;
            byte_cnt <= byte_cnt + 1'b1;
          end
          state <= ST_LISTEN;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == ST_CAPTURE) begin
      wr_addr <= byte_cnt[BUF_AW-1:0];
      wr_data <= i_rdata;
    end
  end

  assign bus.addr  = wr_addr;
  assign bus.we    = wr_en;
  assign bus.wdata = wr_data;
  assign bus.en    = wr_en;
  assign o_len     = byte_cnt;

endmodule

`default_nettype wire

// ==== frame_transmitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_transmitter (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_start,
  input  logic [mhp_pkg::BUF_AW-1:0] i_len,
  buf_if.master                      bus,
  output logic [7:0]                 o_wdata,
  output logic                       o_wvalid,
  input  logic                       i_wready,
  output logic                       o_done
);
  import mhp_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_NEXT,
    ST_WAIT,
    ST_LOAD,
    ST_SEND
  } state_e;

  state_e            state;
  logic [BUF_AW-1:0] idx;
  logic              rd_en;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= ST_IDLE;
      idx      <= '0;
      rd_en    <= 1'b0;
      o_wvalid <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_start) begin
            idx   <= '0;
            state <= ST_NEXT;
          end
        end
        ST_NEXT: begin
          // past the reply length only padding goes out
          if (idx < i_len) begin
            rd_en <= 1'b1;
            state <= ST_WAIT;
          end else begin
            o_wvalid <= 1'b1;
            state    <= ST_SEND;
          end
        end
        ST_WAIT: begin
          rd_en <= 1'b0;
          state <= ST_LOAD;
        end
        ST_LOAD: begin
          o_wvalid <= 1'b1;
          state    <= ST_SEND;
        end
        ST_SEND: begin
          if (i_wready) begin
            o_wvalid <= 1'b0;
            if (idx == BUF_AW'(TX_MIN_LEN - 1)) begin
              o_done <= 1'b1;
              state  <= ST_IDLE;
            end else begin
              idx   <= idx + 1'b1;
              state <= ST_NEXT;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == ST_NEXT) begin
      o_wdata <= '0;
    end else if (state == ST_LOAD) begin
      o_wdata <= bus.rdata;
    end
  end

  assign bus.addr  = idx;
  assign bus.we    = 1'b0;
  assign bus.wdata = '0;
  assign bus.en    = rd_en;

endmodule

`default_nettype wire

// ==== header_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module header_parser (
  input  logic          i_clk,
  input  logic          i_rst,
  input  logic          i_start,
  buf_if.master         bus,
  output logic          o_done,
  output mhp_pkg::hdr_t o_hdr
);
  import mhp_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_WAIT,
    ST_LOAD
  } state_e;

  state_e            state;
  logic [2:0]        idx;
  logic              rd_en;
  logic [BUF_AW-1:0] rd_addr;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= ST_IDLE;
      idx    <= '0;
      rd_en  <= 1'b0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_start) begin
            idx   <= '0;
            state <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          rd_en <= 1'b1;
          state <= ST_WAIT;
        end
        ST_WAIT: begin
          rd_en <= 1'b0;
          state <= ST_LOAD;
        end
        ST_LOAD: begin
          if (idx == 3'(HDR_LEN - 1)) begin
            o_done <= 1'b1;
            state  <= ST_IDLE;
          end else begin
            idx   <= idx + 1'b1;
            state <= ST_ADDR;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // bytes shift in from the bottom, so frame order lands msb first
  always_ff @(posedge i_clk) begin
    if (state == ST_ADDR) begin
      rd_addr <= BUF_AW'(idx);
    end
    if (state == ST_LOAD) begin
      o_hdr <= hdr_t'({o_hdr[HDR_LEN*8-9:0], bus.rdata});
    end
  end

  assign bus.addr  = rd_addr;
  assign bus.we    = 1'b0;
  assign bus.wdata = '0;
  assign bus.en    = rd_en;

endmodule

`default_nettype wire

// ==== mhp_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mhp_assert (
  input wire logic       i_clk,
  input wire logic       i_rst,
  input wire logic       o_rreq,
  input wire logic       o_wvalid,
  input wire logic [7:0] o_wdata,
  input wire logic       i_wready
);

  int fail_cnt = 0;

  // byte under back-pressure stays put until accepted
  a_wdata_held: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (o_wvalid && !i_wready) |=> (o_wvalid && $stable(o_wdata))
  ) else begin
    $error("o_wdata or o_wvalid changed before i_wready");
    fail_cnt++;
  end

  a_rreq_single: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_rreq |=> !o_rreq
  ) else begin
    $error("o_rreq high in two consecutive cycles");
    fail_cnt++;
  end

  // receive and transmit never overlap
  a_rx_tx_apart: assert property (
    @(posedge i_clk) disable iff (i_rst)
    !(o_rreq && o_wvalid)
  ) else begin
    $error("o_rreq and o_wvalid high together");
    fail_cnt++;
  end

endmodule

bind mhp_top mhp_assert mhp_assert_i (
  .i_clk    (i_clk),
  .i_rst    (i_rst),
  .o_rreq   (o_rreq),
  .o_wvalid (o_wvalid),
  .o_wdata  (o_wdata),
  .i_wready (i_wready)
);

`default_nettype wire

// ==== mhp_pkg.sv ====
`default_nettype none

package mhp_pkg;

  ////////////////////////////////////////////////////////////////////
  // sizes and timing
  ////////////////////////////////////////////////////////////////////

  localparam int BUF_AW         = 8;
  localparam int HDR_LEN        = 7;
  localparam int RX_IDLE_CYCLES = 63;
  localparam int TX_MIN_LEN     = 16;
  localparam int TYPE_ACK_BIT   = 4;

  ////////////////////////////////////////////////////////////////////
  // frame types
  ////////////////////////////////////////////////////////////////////

  // header as it sits in the frame, first byte in the top bits
  typedef struct packed {
    logic [15:0] src;
    logic [15:0] dst;
    logic [15:0] size;
    logic [7:0]  typ;
  } hdr_t;

  // reply opcodes, same codes as the type byte
  typedef enum logic [4:0] {
    CMD_PING       = 5'd1,
    CMD_ADDR_GRANT = 5'd4
  } cmd_e;

  typedef enum logic [1:0] {
    PH_RX,
    PH_PARSE,
    PH_BUILD,
    PH_TX
  } phase_e;

endpackage

`default_nettype wire

// ==== mhp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mhp_top (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic [7:0] i_rdata,
  input  logic       i_rready,
  output logic       o_rreq,
  output logic [7:0] o_wdata,
  input  logic       i_wready,
  output logic       o_wvalid,
  output logic       o_addr_granted
);
  import mhp_pkg::*;

  buf_if rx_bus ();
  buf_if prs_bus ();
  buf_if bld_bus ();
  buf_if tx_bus ();
  buf_if mem_bus ();

  phase_e            phase;
  logic              busy;
  logic              start_q;
  logic              granted;
  cmd_e              cmd_q;
  cmd_e              next_cmd;
  logic              reply_en;
  hdr_t              hdr;
  logic [BUF_AW:0]   rx_len;
  logic [BUF_AW-1:0] bld_len;
  logic              rx_done;
  logic              prs_done;
  logic              bld_done;
  logic              tx_done;

  ////////////////////////////////////////////////////////////////////
  // reply decision
  ////////////////////////////////////////////////////////////////////

  // bit 7 of the type byte is the direction and plays no part
  always_comb begin
    reply_en = 1'b0;
    next_cmd = CMD_PING;
    if (!hdr.typ[TYPE_ACK_BIT]) begin
      if (!granted) begin
        reply_en = 1'b1;
        next_cmd = CMD_ADDR_GRANT;
      end else if (hdr.typ[6:0] == 7'(CMD_PING)) begin
        reply_en = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // phase sequencer
  ////////////////////////////////////////////////////////////////////

  // one start pulse per phase, next phase on the block's done
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      phase   <= PH_RX;
      busy    <= 1'b0;
      start_q <= 1'b0;
      granted <= 1'b0;
      cmd_q   <= CMD_PING;
    end else begin
      start_q <= 1'b0;
      if (!busy) begin
        start_q <= 1'b1;
        busy    <= 1'b1;
      end else begin
        case (phase)
          PH_RX: begin
            if (rx_done) begin
              busy <= 1'b0;
              if (rx_len >= HDR_LEN) begin
                phase <= PH_PARSE;
              end
            end
          end
          PH_PARSE: begin
            if (prs_done) begin
              busy  <= 1'b0;
              cmd_q <= next_cmd;
              phase <= reply_en ? PH_BUILD : PH_RX;
            end
          end
          PH_BUILD: begin
            if (bld_done) begin
              busy  <= 1'b0;
              phase <= PH_TX;
            end
          end
          default: begin
            if (tx_done) begin
              busy  <= 1'b0;
              phase <= PH_RX;
              if (cmd_q == CMD_ADDR_GRANT) begin
                granted <= 1'b1;
              end
            end
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // buffer port mux
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    case (phase)
      PH_RX: begin
        mem_bus.addr  = rx_bus.addr;
        mem_bus.we    = rx_bus.we;
        mem_bus.wdata = rx_bus.wdata;
        mem_bus.en    = rx_bus.en;
      end
      PH_PARSE: begin
        mem_bus.addr  = prs_bus.addr;
        mem_bus.we    = prs_bus.we;
        mem_bus.wdata = prs_bus.wdata;
        mem_bus.en    = prs_bus.en;
      end
      PH_BUILD: begin
        mem_bus.addr  = bld_bus.addr;
        mem_bus.we    = bld_bus.we;
        mem_bus.wdata = bld_bus.wdata;
        mem_bus.en    = bld_bus.en;
      end
      default: begin
        mem_bus.addr  = tx_bus.addr;
        mem_bus.we    = tx_bus.we;
        mem_bus.wdata = tx_bus.wdata;
        mem_bus.en    = tx_bus.en;
      end
    endcase
  end

  assign rx_bus.rdata  = (phase == PH_RX) ? mem_bus.rdata : '0;
  assign prs_bus.rdata = (phase == PH_PARSE) ? mem_bus.rdata : '0;
  assign bld_bus.rdata = (phase == PH_BUILD) ? mem_bus.rdata : '0;
  assign tx_bus.rdata  = (phase == PH_TX) ? mem_bus.rdata : '0;

  frame_buf frame_buf_i (
    .i_clk (i_clk),
    .bus   (mem_bus.memory)
  );

  frame_receiver frame_receiver_i (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (start_q && (phase == PH_RX)),
    .i_rdata  (i_rdata),
    .i_rready (i_rready),
    .o_rreq   (o_rreq),
    .bus      (rx_bus.master),
    .o_done   (rx_done),
    .o_len    (rx_len)
  );

  header_parser header_parser_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (start_q && (phase == PH_PARSE)),
    .bus     (prs_bus.master),
    .o_done  (prs_done),
    .o_hdr   (hdr)
  );

  reply_builder reply_builder_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (start_q && (phase == PH_BUILD)),
    .i_cmd   (cmd_q),
    .i_hdr   (hdr),
    .bus     (bld_bus.master),
    .o_done  (bld_done),
    .o_len   (bld_len)
  );

  frame_transmitter frame_transmitter_i (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (start_q && (phase == PH_TX)),
    .i_len    (bld_len),
    .bus      (tx_bus.master),
    .o_wdata  (o_wdata),
    .o_wvalid (o_wvalid),
    .i_wready (i_wready),
    .o_done   (tx_done)
  );

  assign o_addr_granted = granted;

endmodule

`default_nettype wire

// ==== reply_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module reply_builder (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_start,
  input  mhp_pkg::cmd_e              i_cmd,
  input  mhp_pkg::hdr_t              i_hdr,
  buf_if.master                      bus,
  output logic                       o_done,
  output logic [mhp_pkg::BUF_AW-1:0] o_len
);
  import mhp_pkg::*;

  localparam int PING_LEN  = 10;
  localparam int GRANT_LEN = 11;

  // last two bytes of each template hold the checksum
  localparam logic [7:0] PING_TMPL [PING_LEN] = '{
    8'hff, 8'hff, 8'h00, 8'h00, 8'h00, 8'h01, 8'h81, 8'h00, 8'h00, 8'h00
  };
  localparam logic [7:0] GRANT_TMPL [GRANT_LEN] = '{
    8'hff, 8'hff, 8'h00, 8'h00, 8'h00, 8'h02, 8'h92, 8'h01, 8'h20, 8'h00, 8'h00
  };

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_TMPL,
    ST_SWAP,
    ST_RD_ADDR,
    ST_RD_WAIT,
    ST_RD_ACC,
    ST_CK_HI,
    ST_CK_LO
  } state_e;

  state_e            state;
  cmd_e              cmd_q;
  logic [BUF_AW-1:0] idx;
  logic [BUF_AW-1:0] addr_q;
  logic [7:0]        wdata_q;
  logic              wr_en;
  logic              rd_en;
  logic [15:0]       sum;
  logic [7:0]        tmpl_byte;
  logic [7:0]        swap_byte;

  assign tmpl_byte = (cmd_q == CMD_ADDR_GRANT) ? GRANT_TMPL[idx[3:0]] : PING_TMPL[idx[3:0]];

  // reply source is the received destination and vice versa
  always_comb begin
    case (idx[1:0])
      2'd0:    swap_byte = i_hdr.dst[15:8];
      2'd1:    swap_byte = i_hdr.dst[7:0];
      2'd2:    swap_byte = i_hdr.src[15:8];
      default: swap_byte = i_hdr.src[7:0];
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= ST_IDLE;
      cmd_q  <= CMD_PING;
      idx    <= '0;
      o_len  <= '0;
      wr_en  <= 1'b0;
      rd_en  <= 1'b0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      wr_en  <= 1'b0;
      rd_en  <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_start) begin
            cmd_q <= i_cmd;
            o_len <= (i_cmd == CMD_ADDR_GRANT) ? BUF_AW'(GRANT_LEN) : BUF_AW'(PING_LEN);
            idx   <= '0;
            state <= ST_TMPL;
          end
        end
        ST_TMPL: begin
          wr_en <= 1'b1;
          idx   <= idx + 1'b1;
          if (idx == o_len - 1'b1) begin
            idx   <= '0;
            state <= ST_SWAP;
          end
        end
        ST_SWAP: begin
          wr_en <= 1'b1;
          idx   <= idx + 1'b1;
          if (idx == BUF_AW'(3)) begin
            idx   <= '0;
            state <= ST_RD_ADDR;
          end
        end
        ST_RD_ADDR: begin
          rd_en <= 1'b1;
          state <= ST_RD_WAIT;
        end
        ST_RD_WAIT: begin
          state <= ST_RD_ACC;
        end
        ST_RD_ACC: begin
          if (idx == o_len - 2'd3) begin
            state <= ST_CK_HI;
          end else begin
            idx   <= idx + 1'b1;
            state <= ST_RD_ADDR;
          end
        end
        ST_CK_HI: begin
          wr_en <= 1'b1;
          state <= ST_CK_LO;
        end
        ST_CK_LO: begin
          wr_en  <= 1'b1;
          o_done <= 1'b1;
          state  <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // write data and running sum
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    case (state)
      ST_TMPL: begin
        addr_q  <= idx;
        wdata_q <= tmpl_byte;
      end
      ST_SWAP: begin
        addr_q  <= idx;
        wdata_q <= swap_byte;
        sum     <= '0;
      end
      ST_RD_ADDR: addr_q <= idx;
      ST_RD_ACC:  sum <= sum + {8'h00, bus.rdata};
      ST_CK_HI: begin
        addr_q  <= o_len - 2'd2;
        wdata_q <= sum[15:8];
      end
      ST_CK_LO: begin
        addr_q  <= o_len - 1'b1;
        wdata_q <= sum[7:0];
      end
      default: ;
    endcase
  end

  assign bus.addr  = addr_q;
  assign bus.we    = wr_en;
  assign bus.wdata = wdata_q;
  assign bus.en    = wr_en | rd_en;

endmodule

`default_nettype wire

// ==== sources.f ====
mhp_pkg.sv
buf_if.sv
frame_buf.sv
frame_receiver.sv
header_parser.sv
reply_builder.sv
frame_transmitter.sv
mhp_top.sv
mhp_assert.sv
tb_mhp.sv

// ==== tb_mhp.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mhp;

  localparam int CLK_PERIOD      = 20;
  localparam int N_TESTS         = 5;
  localparam int CYCLES_PER_TEST = 3000;
  localparam int WATCHDOG_NS     = N_TESTS * CYCLES_PER_TEST * CLK_PERIOD;
  localparam int REPLY_LEN       = 16;
  localparam int REPLY_TIMEOUT   = 2000;
  localparam int RREQ_TIMEOUT    = 1000;
  localparam int SILENT_CYCLES   = 500;

  // reply templates, checksum bytes left at zero
  localparam logic [7:0] PING_REPLY [10] = '{
    8'hff, 8'hff, 8'h00, 8'h00, 8'h00, 8'h01, 8'h81, 8'h00, 8'h00, 8'h00
  };
  localparam logic [7:0] GRANT_REPLY [11] = '{
    8'hff, 8'hff, 8'h00, 8'h00, 8'h00, 8'h02, 8'h92, 8'h01, 8'h20, 8'h00, 8'h00
  };

  logic       i_clk;
  logic       i_rst;
  logic [7:0] i_rdata;
  logic       i_rready;
  logic       o_rreq;
  logic [7:0] o_wdata;
  logic       i_wready;
  logic       o_wvalid;
  logic       o_addr_granted;

  logic [31:0] lcg_state;
  int          err_cnt;
  logic [7:0]  frame_q [$];
  logic [7:0]  exp_q [REPLY_LEN];
  logic [7:0]  got_q [REPLY_LEN];

  mhp_top mhp_top_i (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_rdata        (i_rdata),
    .i_rready       (i_rready),
    .o_rreq         (o_rreq),
    .o_wdata        (o_wdata),
    .i_wready       (i_wready),
    .o_wvalid       (o_wvalid),
    .o_addr_granted (o_addr_granted)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    fail_run("watchdog expired before the tests finished");
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  task automatic reset_dut();
    i_rst    <= 1'b1;
    i_rdata  <= 8'h00;
    i_rready <= 1'b0;
    i_wready <= 1'b0;
    repeat (2) @(posedge i_clk);
    i_rst <= 1'b0;
    @(posedge i_clk);
  endtask

  // header is src, dst, size, type, then payload
  task automatic make_frame(input logic [15:0] src, input logic [15:0] dst,
                            input logic [7:0] typ, input int n_payload);
    logic [15:0] size;
    logic [31:0] r;
    size = 16'(7 + n_payload);
    frame_q.delete();
    frame_q.push_back(src[15:8]);
    frame_q.push_back(src[7:0]);
    frame_q.push_back(dst[15:8]);
    frame_q.push_back(dst[7:0]);
    frame_q.push_back(size[15:8]);
    frame_q.push_back(size[7:0]);
    frame_q.push_back(typ);
    for (int i = 0; i < n_payload; i++) begin
      r = lcg_next();
      frame_q.push_back(r[23:16]);
    end
  endtask

  // model FIFO, one byte per request in the following cycle
  task automatic send_frame();
    int idx;
    int waited;
    idx = 0;
    waited = 0;
    @(posedge i_clk);
    i_rready <= 1'b1;
    while (idx < frame_q.size()) begin
      @(posedge i_clk);
      if (o_rreq) begin
        i_rdata <= frame_q[idx];
        idx++;
        waited = 0;
        if (idx == frame_q.size()) begin
          i_rready <= 1'b0;
        end
      end else begin
        waited++;
        if (waited > RREQ_TIMEOUT) begin
          fail_run("receiver stopped requesting bytes of the frame");
        end
      end
    end
  endtask

  task automatic collect_reply(input logic random_ready);
    int n;
    int waited;
    logic [31:0] r;
    n = 0;
    waited = 0;
    while (n < REPLY_LEN) begin
      @(posedge i_clk);
      if (o_wvalid && i_wready) begin
        got_q[n] = o_wdata;
        n++;
        waited = 0;
      end else begin
        waited++;
        if (waited > REPLY_TIMEOUT) begin
          fail_run("reply byte did not arrive on the write port in time");
        end
      end
      if (random_ready) begin
        r = lcg_next();
        i_wready <= r[16];
      end else begin
        i_wready <= 1'b1;
      end
    end
    i_wready <= 1'b0;
  endtask

  task automatic build_expected(input logic grant, input logic [15:0] src,
                                input logic [15:0] dst);
    int len;
    logic [15:0] sum;
    for (int i = 0; i < REPLY_LEN; i++) begin
      exp_q[i] = 8'h00;
    end
    if (grant) begin
      len = 11;
      for (int i = 0; i < 11; i++) exp_q[i] = GRANT_REPLY[i];
    end else begin
      len = 10;
      for (int i = 0; i < 10; i++) exp_q[i] = PING_REPLY[i];
    end
    exp_q[0] = dst[15:8];
    exp_q[1] = dst[7:0];
    exp_q[2] = src[15:8];
    exp_q[3] = src[7:0];
    sum = 16'h0000;
    for (int i = 0; i < len - 2; i++) begin
      sum = sum + {8'h00, exp_q[i]};
    end
    exp_q[len-2] = sum[15:8];
    exp_q[len-1] = sum[7:0];
  endtask

  task automatic compare_reply();
    for (int i = 0; i < REPLY_LEN; i++) begin
      check_value($sformatf("o_wdata[byte %0d]", i), got_q[i], exp_q[i]);
    end
  endtask

  task automatic expect_silence(input int cycles);
    repeat (cycles) begin
      @(posedge i_clk);
      if (o_wvalid) begin
        fail_run("write port sent a reply where none was expected");
      end
    end
  endtask

  task automatic exchange_ping(input logic random_ready);
    logic [31:0] r;
    logic [15:0] src;
    logic [15:0] dst;
    r = lcg_next();
    src = r[31:16];
    r = lcg_next();
    dst = r[31:16];
    make_frame(src, dst, 8'h01, 4);
    send_frame();
    collect_reply(random_ready);
    build_expected(1'b0, src, dst);
    compare_reply();
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic grant_first_frame();
    logic [31:0] r;
    logic [15:0] src;
    logic [15:0] dst;
    int waited;
    check_value("o_addr_granted", o_addr_granted, 0);
    r = lcg_next();
    src = r[31:16];
    r = lcg_next();
    dst = r[31:16];
    make_frame(src, dst, 8'h01, 2);
    send_frame();
    collect_reply(1'b0);
    build_expected(1'b1, src, dst);
    compare_reply();
    waited = 0;
    while (!o_addr_granted && waited < 16) begin
      @(posedge i_clk);
      waited++;
    end
    check_value("o_addr_granted", o_addr_granted, 1);
  endtask

  task automatic ping_after_grant();
    exchange_ping(1'b0);
  endtask

  task automatic ignore_ack_and_unknown();
    make_frame(16'h2345, 16'h6789, 8'h07, 0);
    send_frame();
    expect_silence(SILENT_CYCLES);
    check_value("o_addr_granted", o_addr_granted, 1);
    // an ack before any grant still gets no reply and no grant
    reset_dut();
    make_frame(16'h1234, 16'h5678, 8'h11, 1);
    send_frame();
    expect_silence(SILENT_CYCLES);
    check_value("o_addr_granted", o_addr_granted, 0);
    grant_first_frame();
    exchange_ping(1'b0);
  endtask

  task automatic drop_short_frame();
    logic [31:0] r;
    frame_q.delete();
    for (int i = 0; i < 5; i++) begin
      r = lcg_next();
      frame_q.push_back(r[31:24]);
    end
    send_frame();
    expect_silence(SILENT_CYCLES);
    exchange_ping(1'b0);
  endtask

  task automatic ping_under_backpressure();
    exchange_ping(1'b1);
  endtask

  initial begin
    lcg_state = 32'h45026574;
    err_cnt   = 0;
    reset_dut();
    check_value("o_rreq", o_rreq, 0);
    check_value("o_wvalid", o_wvalid, 0);
    check_value("o_addr_granted", o_addr_granted, 0);

    grant_first_frame();
    ping_after_grant();
    ignore_ack_and_unknown();
    drop_short_frame();
    ping_under_backpressure();

    if (err_cnt == 0 && mhp_top_i.mhp_assert_i.fail_cnt == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      fail_run("one or more checks failed");
    end
  end

endmodule

`default_nettype wire
